/* decode_assertions.sv */
module decode_assertions
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         keep,
    input  logic         nop,
    input  reg_addr_t    read_reg1,
    input  reg_addr_t    read_reg2,
    input  word_t        read_data1,
    input  word_t        read_data2,
    input  word_t        rs1_data_q,
    input  word_t        rs2_data_q,
    input  word_t        pc_q,
    input  word_t        imm_q,
    input  alu_src_t     alu_src_q,
    input  mem_rw_t      mem_rw_q,
    input  branch_kind_t branch_kind_q,
    input  wb_ctrl_t     wb_ctrl_q,
    input  reg_addr_t    wb_reg_q,
    input  logic         branch_taken
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;
    logic [143:0] stage_bits;

    // the registered fields seen by the later stages
    assign stage_bits = {rs1_data_q, rs2_data_q, pc_q, imm_q, alu_src_q, mem_rw_q,
                         branch_kind_q, wb_ctrl_q, wb_reg_q};

    nop_clears: assert property (@(posedge clk) disable iff (!rst)
        nop |=> (stage_bits == '0))
        else begin
            fail_count++;
            $error("nop did not clear the stage register");
        end

    keep_holds: assert property (@(posedge clk) disable iff (!rst)
        (keep && !nop) |=> $stable(stage_bits))
        else begin
            fail_count++;
            $error("stage register changed while keep was high");
        end

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst)
        (read_reg1 != '0 || read_data1 == '0) && (read_reg2 != '0 || read_data2 == '0))
        else begin
            fail_count++;
            $error("a read of x0 returned a nonzero value");
        end

    // a branch neither writes a register nor touches memory
    taken_is_branch: assert property (@(posedge clk) disable iff (!rst)
        branch_taken |-> (mem_rw_q == MEM_NONE && !wb_ctrl_q[2]))
        else begin
            fail_count++;
            $error("branch taken with a memory or writeback control set");
        end

endmodule

/* decode_stage.sv */
module decode_stage
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         keep,
    input  logic         nop,
    input  word_t        pc_in,
    input  word_t        pc_plus4_in,
    input  word_t        instr,
    input  word_t        read_data1,
    input  word_t        read_data2,
    input  fwd_sel_t     fwd_ex_sel,
    input  fwd_sel_t     fwd_mem_sel,
    input  fwd_sel_t     fwd_load_sel,
    input  fwd_sel_t     fwd_hazard_sel,
    input  word_t        fwd_ex_data,
    input  word_t        fwd_mem_data,
    input  word_t        fwd_load_data,
    input  word_t        fwd_hazard_data,
    output reg_addr_t    read_reg1,
    output reg_addr_t    read_reg2,
    output word_t        rs1_data_q,
    output word_t        rs2_data_q,
    output word_t        pc_q,
    output word_t        pc_plus4_q,
    output word_t        imm_q,
    output alu_op_e      alu_op_q,
    output alu_src_t     alu_src_q,
    output funct3_t      funct3_q,
    output logic         is_csr_q,
    output mem_rw_t      mem_rw_q,
    output branch_kind_t branch_kind_q,
    output reg_addr_t    wb_reg_q,
    output wb_ctrl_t     wb_ctrl_q,
    output logic         branch_taken,
    output word_t        branch_target
);

    opcode_t      opcode;
    funct3_t      funct3;
    reg_addr_t    rd;
    word_t        imm;
    alu_src_t     alu_src_d;
    mem_rw_t      mem_rw_d;
    branch_kind_t branch_kind_d;
    wb_ctrl_t     wb_ctrl_d;
    reg_addr_t    wb_reg_d;
    alu_op_e      alu_op_d;
    logic [3:0]   rs1_hit;
    logic [3:0]   rs2_hit;
    logic [3:0][31:0] fwd_data;
    word_t        rs1_early;
    word_t        rs2_early;
    logic         operands_equal;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rd        = instr[11:7];
    assign read_reg1 = instr[19:15];
    assign read_reg2 = instr[24:20];

    imm_gen imm_gen_i (
        .instr (instr),
        .imm   (imm)
    );

    // control fields per opcode
    always_comb begin
        alu_src_d     = ALU_SRC_NONE;
        mem_rw_d      = MEM_NONE;
        branch_kind_d = BR_NONE;
        wb_ctrl_d     = WB_NONE;
        wb_reg_d      = '0;
        case (opcode)
            OP_LUI: begin
                wb_ctrl_d = WB_ALU;
                wb_reg_d  = rd;
            end
            OP_AUIPC: begin
                alu_src_d = ALU_SRC_A_PC | ALU_SRC_B_IMM;
                wb_ctrl_d = WB_ALU;
                wb_reg_d  = rd;
            end
            OP_JAL: begin
                alu_src_d     = ALU_SRC_A_PC | ALU_SRC_B_IMM;
                branch_kind_d = BR_JUMP;
                wb_ctrl_d     = WB_PC4;
                wb_reg_d      = rd;
            end
            OP_JALR: begin
                alu_src_d     = ALU_SRC_B_IMM;
                branch_kind_d = BR_JUMP;
                wb_ctrl_d     = WB_PC4;
                wb_reg_d      = rd;
            end
            OP_LOAD: begin
                alu_src_d = ALU_SRC_B_IMM;
                mem_rw_d  = MEM_LOAD;
                wb_ctrl_d = WB_MEM;
                wb_reg_d  = rd;
            end
            OP_STORE: begin
                alu_src_d = ALU_SRC_B_IMM;
                mem_rw_d  = MEM_STORE;
            end
            OP_ALUI, OP_SYSTEM: begin
                // system keeps rs1 and imm around for the csr unit
                alu_src_d = ALU_SRC_B_IMM;
                wb_ctrl_d = WB_ALU;
                wb_reg_d  = rd;
            end
            OP_ALU: begin
                alu_src_d = ALU_SRC_B_REG;
                wb_ctrl_d = WB_ALU;
                wb_reg_d  = rd;
            end
            OP_BRA: begin
                alu_src_d = ALU_SRC_B_REG;
                case (funct3)
                    FCT3_BEQ: branch_kind_d = BR_EQ;
                    FCT3_BNE: branch_kind_d = BR_NE;
                    // blt, bge, bltu, bgeu
                    3'b100:   branch_kind_d = BR_LT;
                    3'b101:   branch_kind_d = BR_GE;
                    3'b110:   branch_kind_d = BR_LTU;
                    3'b111:   branch_kind_d = BR_GEU;
                    default:  branch_kind_d = BR_NONE;
                endcase
            end
            default: begin
                // unknown opcode decodes as a bubble
                alu_src_d = ALU_SRC_NONE;
            end
        endcase
    end

    // alu operation from funct3 and bit 30
    always_comb begin
        alu_op_d = ALU_ADD;
        if (opcode == OP_BRA) begin
            case (funct3)
                3'b110, 3'b111: alu_op_d = ALU_SLTU;
                3'b100, 3'b101: alu_op_d = ALU_SLT;
                default:        alu_op_d = ALU_SUB;
            endcase
        end else if (opcode == OP_ALU || opcode == OP_ALUI) begin
            case (funct3)
                FCT3_ADD:  alu_op_d = (opcode == OP_ALU && instr[30]) ? ALU_SUB : ALU_ADD;
                FCT3_SLL:  alu_op_d = ALU_SLL;
                FCT3_SLT:  alu_op_d = ALU_SLT;
                FCT3_SLTU: alu_op_d = ALU_SLTU;
                FCT3_XOR:  alu_op_d = ALU_XOR;
                FCT3_SRL:  alu_op_d = instr[30] ? ALU_SRA : ALU_SRL;
                FCT3_OR:   alu_op_d = ALU_OR;
                FCT3_AND:  alu_op_d = ALU_AND;
                default:   alu_op_d = ALU_ADD;
            endcase
        end
    end

    // stage register, nop wins over keep
    always_ff @(posedge clk or negedge rst) begin
        if (!rst || nop) begin
            rs1_data_q    <= '0;
            rs2_data_q    <= '0;
            pc_q          <= '0;
            pc_plus4_q    <= '0;
            imm_q         <= '0;
            alu_op_q      <= ALU_ADD;
            alu_src_q     <= ALU_SRC_NONE;
            funct3_q      <= '0;
            is_csr_q      <= 1'b0;
            mem_rw_q      <= MEM_NONE;
            branch_kind_q <= BR_NONE;
            wb_reg_q      <= '0;
            wb_ctrl_q     <= WB_NONE;
        end else if (!keep) begin
            rs1_data_q    <= read_data1;
            rs2_data_q    <= read_data2;
            pc_q          <= pc_in;
            pc_plus4_q    <= pc_plus4_in;
            imm_q         <= imm;
            alu_op_q      <= alu_op_d;
            alu_src_q     <= alu_src_d;
            funct3_q      <= funct3;
            is_csr_q      <= (opcode == OP_SYSTEM);
            mem_rw_q      <= mem_rw_d;
            branch_kind_q <= branch_kind_d;
            wb_reg_q      <= wb_reg_d;
            wb_ctrl_q     <= wb_ctrl_d;
        end
    end

    // highest set bit wins, ex sits at bit 3
    function automatic word_t early_operand(input logic [3:0] hit,
                                            input logic [3:0][31:0] data,
                                            input word_t fallback);
        word_t val;
        val = fallback;
        for (int i = 0; i < 4; i++) begin
            if (hit[i]) begin
                val = data[i];
            end
        end
        return val;
    endfunction

    assign fwd_data = {fwd_ex_data, fwd_mem_data, fwd_load_data, fwd_hazard_data};
    assign rs1_hit  = {fwd_ex_sel[FWD_RS1_BIT], fwd_mem_sel[FWD_RS1_BIT],
                       fwd_load_sel[FWD_RS1_BIT], fwd_hazard_sel[FWD_RS1_BIT]};
    assign rs2_hit  = {fwd_ex_sel[FWD_RS2_BIT], fwd_mem_sel[FWD_RS2_BIT],
                       fwd_load_sel[FWD_RS2_BIT], fwd_hazard_sel[FWD_RS2_BIT]};

    assign rs1_early      = early_operand(rs1_hit, fwd_data, rs1_data_q);
    assign rs2_early      = early_operand(rs2_hit, fwd_data, rs2_data_q);
    assign operands_equal = (rs1_early == rs2_early);

    // only beq and bne resolve here, the rest goes on to execute
    assign branch_taken = !keep && (branch_kind_q != BR_NONE) &&
                          (((branch_kind_q == BR_EQ) && (funct3_q == FCT3_BEQ) &&
                            operands_equal) ||
                           ((branch_kind_q == BR_NE) && (funct3_q == FCT3_BNE) &&
                            !operands_equal));

    assign branch_target = pc_q + imm_q;

endmodule

/* id_subsystem.sv */
module id_subsystem
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         keep,
    input  logic         nop,
    input  word_t        pc_in,
    input  word_t        pc_plus4_in,
    input  word_t        instr,
    input  logic         wb_en,
    input  reg_addr_t    wb_addr,
    input  word_t        wb_data,
    input  fwd_sel_t     fwd_ex_sel,
    input  word_t        fwd_ex_data,
    input  fwd_sel_t     fwd_mem_sel,
    input  word_t        fwd_mem_data,
    input  fwd_sel_t     fwd_load_sel,
    input  word_t        fwd_load_data,
    input  fwd_sel_t     fwd_hazard_sel,
    input  word_t        fwd_hazard_data,
    output word_t        rs1_data_q,
    output word_t        rs2_data_q,
    output word_t        pc_q,
    output word_t        pc_plus4_q,
    output word_t        imm_q,
    output alu_op_e      alu_op_q,
    output alu_src_t     alu_src_q,
    output funct3_t      funct3_q,
    output logic         is_csr_q,
    output mem_rw_t      mem_rw_q,
    output branch_kind_t branch_kind_q,
    output reg_addr_t    wb_reg_q,
    output wb_ctrl_t     wb_ctrl_q,
    output logic         branch_taken,
    output word_t        branch_target
);

    // register file read path
    reg_addr_t read_reg1;
    reg_addr_t read_reg2;
    word_t     read_data1;
    word_t     read_data2;

    register_file register_file_i (
        .clk        (clk),
        .rst        (rst),
        .read_reg1  (read_reg1),
        .read_reg2  (read_reg2),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    decode_stage decode_stage_i (
        .clk             (clk),
        .rst             (rst),
        .keep            (keep),
        .nop             (nop),
        .pc_in           (pc_in),
        .pc_plus4_in     (pc_plus4_in),
        .instr           (instr),
        .read_data1      (read_data1),
        .read_data2      (read_data2),
        .fwd_ex_sel      (fwd_ex_sel),
        .fwd_mem_sel     (fwd_mem_sel),
        .fwd_load_sel    (fwd_load_sel),
        .fwd_hazard_sel  (fwd_hazard_sel),
        .fwd_ex_data     (fwd_ex_data),
        .fwd_mem_data    (fwd_mem_data),
        .fwd_load_data   (fwd_load_data),
        .fwd_hazard_data (fwd_hazard_data),
        .read_reg1       (read_reg1),
        .read_reg2       (read_reg2),
        .rs1_data_q      (rs1_data_q),
        .rs2_data_q      (rs2_data_q),
        .pc_q            (pc_q),
        .pc_plus4_q      (pc_plus4_q),
        .imm_q           (imm_q),
        .alu_op_q        (alu_op_q),
        .alu_src_q       (alu_src_q),
        .funct3_q        (funct3_q),
        .is_csr_q        (is_csr_q),
        .mem_rw_q        (mem_rw_q),
        .branch_kind_q   (branch_kind_q),
        .wb_reg_q        (wb_reg_q),
        .wb_ctrl_q       (wb_ctrl_q),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target)
    );

endmodule

/* imm_gen.sv */
module imm_gen
    import rv_isa_pkg::*;
(
    input  word_t instr,
    output word_t imm
);

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        case (opcode)
            // i format
            OP_LOAD, OP_JALR, OP_SYSTEM: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OP_ALUI: begin
                // shifts carry a plain shamt
                if (funct3 == FCT3_SLL || funct3 == FCT3_SRL) begin
                    imm = {27'b0, instr[24:20]};
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
            OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRA: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* list.f */
rv_isa_pkg.sv
pipe_ctrl_pkg.sv
register_file.sv
imm_gen.sv
decode_stage.sv
id_subsystem.sv
decode_assertions.sv
tb_id_subsystem.sv

/* pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // [2] pc as operand a, [1:0] operand b source
    typedef logic [2:0] alu_src_t;
    // [1] load, [0] store
    typedef logic [1:0] mem_rw_t;
    typedef logic [2:0] branch_kind_t;
    // [2] regwrite, [1:0] writeback source
    typedef logic [2:0] wb_ctrl_t;
    // [1] rs1 hit, [0] rs2 hit
    typedef logic [1:0] fwd_sel_t;

    localparam alu_src_t ALU_SRC_NONE  = 3'b000;
    localparam alu_src_t ALU_SRC_A_PC  = 3'b100;
    localparam alu_src_t ALU_SRC_B_REG = 3'b011;
    localparam alu_src_t ALU_SRC_B_IMM = 3'b010;

    localparam mem_rw_t MEM_NONE  = 2'b00;
    localparam mem_rw_t MEM_LOAD  = 2'b10;
    localparam mem_rw_t MEM_STORE = 2'b01;

    localparam branch_kind_t BR_NONE = 3'b000;
    localparam branch_kind_t BR_EQ   = 3'b001;
    localparam branch_kind_t BR_NE   = 3'b010;
    localparam branch_kind_t BR_LT   = 3'b011;
    localparam branch_kind_t BR_GE   = 3'b100;
    localparam branch_kind_t BR_LTU  = 3'b101;
    localparam branch_kind_t BR_GEU  = 3'b110;
    localparam branch_kind_t BR_JUMP = 3'b111;

    // full writeback control words
    localparam wb_ctrl_t WB_NONE = 3'b000;
    localparam wb_ctrl_t WB_ALU  = 3'b100;
    localparam wb_ctrl_t WB_MEM  = 3'b101;
    localparam wb_ctrl_t WB_PC4  = 3'b110;

    // bit positions inside a forwarding select
    localparam int FWD_RS1_BIT = 1;
    localparam int FWD_RS2_BIT = 0;

endpackage

/* register_file.sv */
module register_file
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t read_reg1,
    input  reg_addr_t read_reg2,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     read_data1,
    output word_t     read_data2
);

    // x0 has no storage
    word_t regs [1:31];

    // one read port, with the write bypass in front of the array
    function automatic word_t read_port(input reg_addr_t addr, input word_t stored);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_en && (wb_addr == addr)) begin
            val = wb_data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // index 0 never reaches the array, the function returns zero first
    assign read_data1 = read_port(read_reg1, (read_reg1 == '0) ? '0 : regs[read_reg1]);
    assign read_data2 = read_port(read_reg2, (read_reg2 == '0) ? '0 : regs[read_reg2]);

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes, instr[6:0]
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRA    = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_ALUI   = 7'b0010011;
    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // funct3 for the integer ALU group
    localparam funct3_t FCT3_ADD  = 3'b000;
    localparam funct3_t FCT3_SLL  = 3'b001;
    localparam funct3_t FCT3_SLT  = 3'b010;
    localparam funct3_t FCT3_SLTU = 3'b011;
    localparam funct3_t FCT3_XOR  = 3'b100;
    localparam funct3_t FCT3_SRL  = 3'b101;
    localparam funct3_t FCT3_OR   = 3'b110;
    localparam funct3_t FCT3_AND  = 3'b111;

    // funct3 for the two branches resolved in decode
    localparam funct3_t FCT3_BEQ  = 3'b000;
    localparam funct3_t FCT3_BNE  = 3'b001;

    // operation code handed to the execute ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

endpackage

/* tb_id_subsystem.sv */
module tb_id_subsystem
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          HALF_PERIOD   = 20;
    localparam int          RESET_CYCLES  = 16;
    localparam int          QUIET_TIMEOUT = 8;
    localparam logic [31:0] SEED          = 32'h415c_0bae;

    logic         clk;
    logic         rst;
    logic         keep;
    logic         nop;
    logic         wb_en;
    reg_addr_t    wb_addr;
    word_t        wb_data;
    word_t        pc_in;
    word_t        pc_plus4_in;
    word_t        instr;
    fwd_sel_t     fwd_ex_sel;
    fwd_sel_t     fwd_mem_sel;
    fwd_sel_t     fwd_load_sel;
    fwd_sel_t     fwd_hazard_sel;
    word_t        fwd_ex_data;
    word_t        fwd_mem_data;
    word_t        fwd_load_data;
    word_t        fwd_hazard_data;
    word_t        rs1_data_q;
    word_t        rs2_data_q;
    word_t        pc_q;
    word_t        pc_plus4_q;
    word_t        imm_q;
    alu_op_e      alu_op_q;
    alu_src_t     alu_src_q;
    funct3_t      funct3_q;
    logic         is_csr_q;
    mem_rw_t      mem_rw_q;
    branch_kind_t branch_kind_q;
    reg_addr_t    wb_reg_q;
    wb_ctrl_t     wb_ctrl_q;
    logic         branch_taken;
    word_t        branch_target;

    integer seed;
    int     err_count;
    int     assert_fails;
    word_t  next_pc;
    word_t  rf_model [0:31];
    // what the stage register should hold after the last edge
    word_t  exp_ins;
    word_t  exp_imm;
    word_t  exp_pc;
    word_t  exp_pc4;
    word_t  exp_rs1;
    word_t  exp_rs2;

    id_subsystem dut_i (.*);

    bind decode_stage decode_assertions decode_assertions_i (.*);

    always #(HALF_PERIOD) clk = ~clk;

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_ALU};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd,
                                    input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRA};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // alu operation for the integer groups
    // alt is instruction bit 30 where it counts
    function automatic alu_op_e alu_from_funct(input funct3_t f3, input logic alt);
        case (f3)
            3'b000: return alt ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return alt ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ex first, then mem, load, hazard
    function automatic word_t pick_operand(input int idx, input word_t fallback);
        if (fwd_ex_sel[idx]) return fwd_ex_data;
        if (fwd_mem_sel[idx]) return fwd_mem_data;
        if (fwd_load_sel[idx]) return fwd_load_data;
        if (fwd_hazard_sel[idx]) return fwd_hazard_data;
        return fallback;
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_quiet();
        check_val("wb_ctrl_q", wb_ctrl_q, '0);
        check_val("mem_rw_q", mem_rw_q, '0);
        check_val("branch_kind_q", branch_kind_q, '0);
        check_val("branch_taken", branch_taken, '0);
    endtask

    task automatic check_outputs();
        opcode_t      op;
        funct3_t      f3;
        alu_src_t     e_src;
        mem_rw_t      e_mem;
        branch_kind_t e_br;
        wb_ctrl_t     e_wb;
        alu_op_e      e_op;
        logic         e_taken;
        op    = exp_ins[6:0];
        f3    = exp_ins[14:12];
        e_src = 3'b000;
        e_mem = 2'b00;
        e_br  = 3'b000;
        e_wb  = 3'b000;
        e_op  = ALU_ADD;
        case (op)
            OP_LUI: e_wb = 3'b100;
            OP_AUIPC: begin
                e_src = 3'b110;
                e_wb  = 3'b100;
            end
            OP_JAL: begin
                e_src = 3'b110;
                e_br  = 3'b111;
                e_wb  = 3'b110;
            end
            OP_JALR: begin
                e_src = 3'b010;
                e_br  = 3'b111;
                e_wb  = 3'b110;
            end
            OP_LOAD: begin
                e_src = 3'b010;
                e_mem = 2'b10;
                e_wb  = 3'b101;
            end
            OP_STORE: begin
                e_src = 3'b010;
                e_mem = 2'b01;
            end
            OP_ALUI: begin
                e_src = 3'b010;
                e_wb  = 3'b100;
                e_op  = alu_from_funct(f3, exp_ins[30] && f3 == 3'b101);
            end
            OP_SYSTEM: begin
                e_src = 3'b010;
                e_wb  = 3'b100;
            end
            OP_ALU: begin
                e_src = 3'b011;
                e_wb  = 3'b100;
                e_op  = alu_from_funct(f3, exp_ins[30]);
            end
            OP_BRA: begin
                e_src = 3'b011;
                // beq 001, bne 010, blt..bgeu one below funct3
                e_br  = (f3 == 3'b000) ? 3'b001 : (f3 == 3'b001) ? 3'b010 :
                        f3[2] ? f3 - 3'd1 : 3'b000;
                e_op  = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
            end
            default: ;
        endcase
        e_taken = !keep && op == OP_BRA &&
                  ((f3 == 3'b000 && pick_operand(1, exp_rs1) == pick_operand(0, exp_rs2)) ||
                   (f3 == 3'b001 && pick_operand(1, exp_rs1) != pick_operand(0, exp_rs2)));
        check_val("alu_src_q", alu_src_q, e_src);
        check_val("mem_rw_q", mem_rw_q, e_mem);
        check_val("branch_kind_q", branch_kind_q, e_br);
        check_val("wb_ctrl_q", wb_ctrl_q, e_wb);
        check_val("wb_reg_q", wb_reg_q, e_wb[2] ? exp_ins[11:7] : 5'd0);
        check_val("alu_op_q", alu_op_q, e_op);
        check_val("funct3_q", funct3_q, f3);
        check_val("is_csr_q", is_csr_q, op == OP_SYSTEM);
        check_val("imm_q", imm_q, exp_imm);
        check_val("pc_q", pc_q, exp_pc);
        check_val("pc_plus4_q", pc_plus4_q, exp_pc4);
        check_val("rs1_data_q", rs1_data_q, exp_rs1);
        check_val("rs2_data_q", rs2_data_q, exp_rs2);
        check_val("branch_taken", branch_taken, e_taken);
        check_val("branch_target", branch_target, exp_pc + exp_imm);
    endtask

    // one instruction through the stage
    // the caller sets the write port and the controls
    task automatic apply(input word_t ins, input word_t imm_val);
        if (wb_en && wb_addr != 5'd0) begin
            rf_model[wb_addr] = wb_data;
        end
        instr       = ins;
        pc_in       = next_pc;
        pc_plus4_in = next_pc + 32'd4;
        if (nop) begin
            exp_ins = '0;
            exp_imm = '0;
            exp_pc  = '0;
            exp_pc4 = '0;
            exp_rs1 = '0;
            exp_rs2 = '0;
        end else if (!keep) begin
            exp_ins = ins;
            exp_imm = imm_val;
            exp_pc  = next_pc;
            exp_pc4 = next_pc + 32'd4;
            exp_rs1 = rf_model[ins[19:15]];
            exp_rs2 = rf_model[ins[24:20]];
        end
        @(posedge clk);
        #1;
        check_outputs();
        wb_en   = 1'b0;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic wait_branch_quiet(input int max_cycles);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (branch_taken && n < max_cycles);
        if (branch_taken) begin
            err_count++;
            $display("timeout: branch_taken stayed high for %0d cycles", max_cycles);
        end
    endtask

    initial begin
        logic [11:0] i12;
        logic [12:0] b13;
        logic [19:0] u20;
        logic [20:0] j21;
        reg_addr_t   ra;
        reg_addr_t   rb;
        seed            = SEED;
        clk             = 1'b0;
        rst             = 1'b0;
        keep            = 1'b0;
        nop             = 1'b0;
        wb_en           = 1'b0;
        wb_addr         = '0;
        wb_data         = '0;
        pc_in           = '0;
        pc_plus4_in     = '0;
        instr           = '0;
        fwd_ex_sel      = '0;
        fwd_mem_sel     = '0;
        fwd_load_sel    = '0;
        fwd_hazard_sel  = '0;
        fwd_ex_data     = '0;
        fwd_mem_data    = '0;
        fwd_load_data   = '0;
        fwd_hazard_data = '0;
        err_count       = 0;
        next_pc         = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_quiet();
        end
        rst = 1'b1;
        check_quiet();

        // fill x1..x7 and read each in the cycle it is written
        for (int r = 1; r < 8; r++) begin
            wb_en   = 1'b1;
            wb_addr = 5'(r);
            wb_data = $random(seed);
            apply(enc_r(7'h00, 5'(r), 5'(r), FCT3_ADD, 5'(r)), '0);
        end
        wb_en   = 1'b1;
        wb_addr = 5'd0;
        wb_data = 32'hdead_beef;
        apply(enc_r(7'h20, 5'd0, 5'd0, FCT3_ADD, 5'd1), '0);
        apply(enc_r(7'h00, 5'd0, 5'd3, FCT3_OR, 5'd2), '0);

        // one of each class
        i12 = 12'($random(seed));
        apply(enc_i(i12, 5'd1, 3'b010, 5'd8, OP_LOAD), sext12(i12));
        u20 = 20'($random(seed));
        apply({u20, 5'd9, OP_LUI}, {u20, 12'b0});
        u20 = 20'($random(seed));
        apply({u20, 5'd10, OP_AUIPC}, {u20, 12'b0});
        j21 = 21'($random(seed));
        j21[0] = 1'b0;
        apply(enc_j(j21, 5'd1), {{11{j21[20]}}, j21});
        i12 = 12'($random(seed));
        apply(enc_i(i12, 5'd2, 3'b000, 5'd1, OP_JALR), sext12(i12));
        i12 = 12'($random(seed));
        apply(enc_s(i12, 5'd3, 5'd4), sext12(i12));
        i12 = 12'($random(seed));
        apply(enc_i(i12, 5'd5, FCT3_ADD, 5'd11, OP_ALUI), sext12(i12));
        apply(enc_i({7'h00, 5'd13}, 5'd6, FCT3_SLL, 5'd12, OP_ALUI), 32'd13);
        apply(enc_i({7'h20, 5'd7}, 5'd6, FCT3_SRL, 5'd12, OP_ALUI), 32'd7);
        apply(enc_r(7'h20, 5'd2, 5'd3, FCT3_ADD, 5'd13), '0);
        apply(enc_r(7'h20, 5'd4, 5'd5, FCT3_SRL, 5'd14), '0);
        apply(enc_r(7'h00, 5'd6, 5'd7, FCT3_SLTU, 5'd15), '0);
        apply(enc_r(7'h00, 5'd6, 5'd7, FCT3_AND, 5'd16), '0);
        b13 = 13'($random(seed));
        b13[0] = 1'b0;
        apply(enc_b(b13, 5'd1, 5'd2, 3'b111), {{19{b13[12]}}, b13});
        i12 = 12'($random(seed));
        apply(enc_i(i12, 5'd1, 3'b001, 5'd17, OP_SYSTEM), sext12(i12));
        apply(32'h1234_567f, '0);

        // keep holds a load and nop then wins over keep
        apply(enc_i(12'h7f0, 5'd2, 3'b010, 5'd18, OP_LOAD), 32'h0000_07f0);
        keep = 1'b1;
        apply(enc_s(12'h004, 5'd1, 5'd2), 32'd4);
        apply(enc_r(7'h00, 5'd1, 5'd1, FCT3_XOR, 5'd19), '0);
        nop = 1'b1;
        apply(enc_r(7'h00, 5'd1, 5'd1, FCT3_XOR, 5'd19), '0);
        nop  = 1'b0;
        keep = 1'b0;

        // blt on equal operands stays with execute
        fwd_ex_sel  = 2'b11;
        fwd_ex_data = 32'd3;
        apply(enc_b(13'h010, 5'd1, 5'd1, 3'b100), 32'h10);
        apply(enc_b(13'h010, 5'd1, 5'd1, FCT3_BEQ), 32'h10);
        // keep blocks the held beq that would be taken
        keep = 1'b1;
        apply(enc_b(13'h010, 5'd1, 5'd1, 3'b100), 32'h10);
        keep = 1'b0;
        wait_branch_quiet(QUIET_TIMEOUT);

        // ex wins for rs1 and mem wins for rs2 over load
        fwd_ex_sel    = 2'b10;
        fwd_ex_data   = 32'd5;
        fwd_mem_sel   = 2'b11;
        fwd_mem_data  = 32'd9;
        fwd_load_sel  = 2'b11;
        fwd_load_data = 32'd5;
        apply(enc_b(13'h020, 5'd1, 5'd2, FCT3_BEQ), 32'h20);
        apply(enc_b(13'h020, 5'd1, 5'd2, FCT3_BNE), 32'h20);

        // random beq and bne over small values so both outcomes occur
        for (int n = 0; n < 40; n++) begin
            fwd_ex_sel      = 2'($random(seed));
            fwd_mem_sel     = 2'($random(seed));
            fwd_load_sel    = 2'($random(seed));
            fwd_hazard_sel  = 2'($random(seed));
            fwd_ex_data     = $random(seed) & 32'd3;
            fwd_mem_data    = $random(seed) & 32'd3;
            fwd_load_data   = $random(seed) & 32'd3;
            fwd_hazard_data = $random(seed) & 32'd3;
            wb_en   = 1'b1;
            wb_addr = 5'($random(seed) & 7);
            wb_data = $random(seed) & 32'd3;
            ra  = 5'($random(seed) & 7);
            rb  = 5'($random(seed) & 7);
            b13 = 13'($random(seed));
            b13[0] = 1'b0;
            apply(enc_b(b13, rb, ra, 3'($random(seed) & 1)), {{19{b13[12]}}, b13});
        end
        fwd_ex_sel     = '0;
        fwd_mem_sel    = '0;
        fwd_load_sel   = '0;
        fwd_hazard_sel = '0;
        apply(enc_i(12'h000, 5'd0, FCT3_ADD, 5'd0, OP_ALUI), '0);
        wait_branch_quiet(QUIET_TIMEOUT);

        assert_fails = dut_i.decode_stage_i.decode_assertions_i.fail_count;
        $display("closing: %0d check errors, %0d assertion failures", err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
